//--- flist.f
+incdir+test
hdl/wb_bus_pkg.sv
hdl/mem_map_pkg.sv
hdl/wb_sram.sv
hdl/wb_bank_router.sv
hdl/wb_mem_subsys.sv
test/tb_wb_mem_subsys.sv

//--- hdl/mem_map_pkg.sv
/* Memory map of the subsystem
   Bank decode result, base addresses, sizes and stall delays of both banks */
package mem_map_pkg;

	typedef enum logic [1:0] {
		FAST_BANK,
		SLOW_BANK,
		NO_BANK
	} bank_e;

	// Zero wait-state bank
	localparam logic [wb_bus_pkg::ADDR_W-1:0] FAST_BASE = 16'h0000;
	localparam int FAST_WORDS = 256;
	localparam int FAST_DELAY = 0;

	// Slow device, stalls after every accepted request
	localparam logic [wb_bus_pkg::ADDR_W-1:0] SLOW_BASE = 16'h1000;
	localparam int SLOW_WORDS = 1024;
	localparam int SLOW_DELAY = 3;

	// Bases as word indexes, for the bank-relative address
	localparam logic [wb_bus_pkg::WORD_ADDR_W-1:0] FAST_BASE_W =
		FAST_BASE[wb_bus_pkg::ADDR_W-1:wb_bus_pkg::LANE_BITS];
	localparam logic [wb_bus_pkg::WORD_ADDR_W-1:0] SLOW_BASE_W =
		SLOW_BASE[wb_bus_pkg::ADDR_W-1:wb_bus_pkg::LANE_BITS];

endpackage

//--- hdl/wb_bank_router.sv
/* Bank router for the memory subsystem
   Decodes the address, steers the strobe and merges both bank responses */
`timescale 1ns/1ps

module wb_bank_router (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                cyc_i,
	input  logic                                stb_i,
	input  logic                                we_i,
	input  logic [wb_bus_pkg::ADDR_W-1:0]      addr_i,
	input  logic [wb_bus_pkg::DATA_W-1:0]      data_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]       sel_i,
	output logic                                fast_stb_o,
	output logic                                slow_stb_o,
	output logic                                bank_cyc_o,
	output logic                                bank_we_o,
	output logic [wb_bus_pkg::WORD_ADDR_W-1:0] bank_addr_o,
	output logic [wb_bus_pkg::DATA_W-1:0]      bank_data_o,
	output logic [wb_bus_pkg::SEL_W-1:0]       bank_sel_o,
	input  logic                                fast_stall_i,
	input  logic                                fast_ack_i,
	input  logic [wb_bus_pkg::DATA_W-1:0]      fast_data_i,
	input  logic                                slow_stall_i,
	input  logic                                slow_ack_i,
	input  logic [wb_bus_pkg::DATA_W-1:0]      slow_data_i,
	output logic                                stall_o,
	output logic                                ack_o,
	output logic                                err_o,
	output logic [wb_bus_pkg::DATA_W-1:0]      data_o
);

	logic [wb_bus_pkg::WORD_ADDR_W-1:0] word_addr;
	logic [wb_bus_pkg::WORD_ADDR_W-1:0] fast_off;
	logic [wb_bus_pkg::WORD_ADDR_W-1:0] slow_off;
	mem_map_pkg::bank_e                 bank_sel;
	logic                               accept;
	logic                               pend_slow_q;

	assign word_addr = addr_i[wb_bus_pkg::ADDR_W-1:wb_bus_pkg::LANE_BITS];

	// Below a base the subtraction wraps, so one compare covers both ends
	assign fast_off = word_addr - mem_map_pkg::FAST_BASE_W;
	assign slow_off = word_addr - mem_map_pkg::SLOW_BASE_W;

	always_comb begin
		if (fast_off < mem_map_pkg::FAST_WORDS) begin
			bank_sel = mem_map_pkg::FAST_BANK;
		end else if (slow_off < mem_map_pkg::SLOW_WORDS) begin
			bank_sel = mem_map_pkg::SLOW_BANK;
		end else begin
			bank_sel = mem_map_pkg::NO_BANK;
		end
	end

	assign fast_stb_o = stb_i && (bank_sel == mem_map_pkg::FAST_BANK);
	assign slow_stb_o = stb_i && (bank_sel == mem_map_pkg::SLOW_BANK);
	assign bank_cyc_o = cyc_i;
	assign bank_we_o = we_i;
	assign bank_data_o = data_i;
	assign bank_sel_o = sel_i;
	assign bank_addr_o = (bank_sel == mem_map_pkg::SLOW_BANK) ? slow_off : fast_off;

	// Unmapped requests never stall and are taken at once
	always_comb begin
		case (bank_sel)
			mem_map_pkg::FAST_BANK: stall_o = fast_stall_i;
			mem_map_pkg::SLOW_BANK: stall_o = slow_stall_i;
			default: stall_o = 1'b0;
		endcase
	end

	assign accept = cyc_i && stb_i && !stall_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			err_o <= 1'b0;
			pend_slow_q <= 1'b0;
		end else begin
			err_o <= accept && (bank_sel == mem_map_pkg::NO_BANK);
			if (accept && (bank_sel != mem_map_pkg::NO_BANK)) begin
				pend_slow_q <= (bank_sel == mem_map_pkg::SLOW_BANK);
			end
		end
	end

	// The flag names the bank that was accepted last, which is the one answering now
	assign ack_o = fast_ack_i || slow_ack_i;
	assign data_o = pend_slow_q ? slow_data_i : fast_data_i;

	a_one_bank_ack: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!(fast_ack_i && slow_ack_i)
	) else $error("wb_bank_router: both banks acked together");

	a_err_excl_ack: assert property (
		@(posedge clk_i) disable iff (rst_i)
		err_o |-> !ack_o
	) else $error("wb_bank_router: err and ack in the same cycle");

endmodule

//--- hdl/wb_bus_pkg.sv
/* Wishbone bus shape
   Widths of the 32-bit pipelined slave port and of the bank-side word address */
package wb_bus_pkg;

	// Data path
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	localparam int SEL_W = DATA_W / BYTE_W;

	// Byte address as seen on the external port
	localparam int ADDR_W = 16;

	// Low address bits that pick a byte within a word
	localparam int LANE_BITS = 2;

	// Word index handed to the banks once the lane bits are dropped
	localparam int WORD_ADDR_W = ADDR_W - LANE_BITS;

endpackage

//--- hdl/wb_mem_subsys.sv
/* Wishbone memory subsystem top level
   Router in front of a zero-wait fast bank and a stalling slow bank */
`timescale 1ns/1ps

module wb_mem_subsys (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  logic                           wb_cyc_i,
	input  logic                           wb_stb_i,
	input  logic                           wb_we_i,
	input  logic [wb_bus_pkg::ADDR_W-1:0] wb_addr_i,
	input  logic [wb_bus_pkg::DATA_W-1:0] wb_data_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]  wb_sel_i,
	output logic                           wb_stall_o,
	output logic                           wb_ack_o,
	output logic                           wb_err_o,
	output logic [wb_bus_pkg::DATA_W-1:0] wb_data_o
);

	logic                                fast_stb;
	logic                                slow_stb;
	logic                                bank_cyc;
	logic                                bank_we;
	logic [wb_bus_pkg::WORD_ADDR_W-1:0] bank_addr;
	logic [wb_bus_pkg::DATA_W-1:0]      bank_data;
	logic [wb_bus_pkg::SEL_W-1:0]       bank_sel;
	logic                                fast_stall;
	logic                                fast_ack;
	logic [wb_bus_pkg::DATA_W-1:0]      fast_data;
	logic                                slow_stall;
	logic                                slow_ack;
	logic [wb_bus_pkg::DATA_W-1:0]      slow_data;

	wb_bank_router i_bank_router (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cyc_i        (wb_cyc_i),
		.stb_i        (wb_stb_i),
		.we_i         (wb_we_i),
		.addr_i       (wb_addr_i),
		.data_i       (wb_data_i),
		.sel_i        (wb_sel_i),
		.fast_stb_o   (fast_stb),
		.slow_stb_o   (slow_stb),
		.bank_cyc_o   (bank_cyc),
		.bank_we_o    (bank_we),
		.bank_addr_o  (bank_addr),
		.bank_data_o  (bank_data),
		.bank_sel_o   (bank_sel),
		.fast_stall_i (fast_stall),
		.fast_ack_i   (fast_ack),
		.fast_data_i  (fast_data),
		.slow_stall_i (slow_stall),
		.slow_ack_i   (slow_ack),
		.slow_data_i  (slow_data),
		.stall_o      (wb_stall_o),
		.ack_o        (wb_ack_o),
		.err_o        (wb_err_o),
		.data_o       (wb_data_o)
	);

	wb_sram #(
		.WORDS (mem_map_pkg::FAST_WORDS),
		.DELAY (mem_map_pkg::FAST_DELAY)
	) i_fast_bank (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.cyc_i   (bank_cyc),
		.stb_i   (fast_stb),
		.we_i    (bank_we),
		.addr_i  (bank_addr),
		.data_i  (bank_data),
		.sel_i   (bank_sel),
		.stall_o (fast_stall),
		.ack_o   (fast_ack),
		.data_o  (fast_data)
	);

	wb_sram #(
		.WORDS (mem_map_pkg::SLOW_WORDS),
		.DELAY (mem_map_pkg::SLOW_DELAY)
	) i_slow_bank (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.cyc_i   (bank_cyc),
		.stb_i   (slow_stb),
		.we_i    (bank_we),
		.addr_i  (bank_addr),
		.data_i  (bank_data),
		.sel_i   (bank_sel),
		.stall_o (slow_stall),
		.ack_o   (slow_ack),
		.data_o  (slow_data)
	);

endmodule

//--- hdl/wb_sram.sv
/* Wishbone pipelined memory bank
   Byte-masked single-port RAM that stalls for DELAY cycles after each request */
`timescale 1ns/1ps

module wb_sram #(
	parameter int WORDS = 256,
	parameter int DELAY = 0
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                cyc_i,
	input  logic                                stb_i,
	input  logic                                we_i,
	input  logic [wb_bus_pkg::WORD_ADDR_W-1:0] addr_i,
	input  logic [wb_bus_pkg::DATA_W-1:0]      data_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]       sel_i,
	output logic                                stall_o,
	output logic                                ack_o,
	output logic [wb_bus_pkg::DATA_W-1:0]      data_o
);

	localparam int MEM_AW = (WORDS > 1) ? $clog2(WORDS) : 1;
	localparam int CNT_W = (DELAY > 0) ? $clog2(DELAY + 1) : 1;

	logic [wb_bus_pkg::DATA_W-1:0] mem [WORDS];
	logic [wb_bus_pkg::DATA_W-1:0] lane_mask;
	logic [wb_bus_pkg::DATA_W-1:0] rd_word;
	logic [MEM_AW-1:0]             mem_idx;
	logic [CNT_W-1:0]              cnt_q;
	logic                          accept;

	// Contents are zero at power-up only
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_comb begin
		for (int l = 0; l < wb_bus_pkg::SEL_W; l++) begin
			lane_mask[l*wb_bus_pkg::BYTE_W +: wb_bus_pkg::BYTE_W] =
				{wb_bus_pkg::BYTE_W{sel_i[l]}};
		end
	end

	assign stall_o = (cnt_q != '0);
	assign accept = cyc_i && stb_i && !stall_o;
	assign mem_idx = addr_i[MEM_AW-1:0];
	assign rd_word = mem[mem_idx];

	// Unselected lanes keep what is already stored
	always_ff @(posedge clk_i) begin
		if (accept && we_i) begin
			mem[mem_idx] <= (data_i & lane_mask) | (rd_word & ~lane_mask);
		end
		if (accept && !we_i) begin
			data_o <= rd_word;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			cnt_q <= '0;
		end else begin
			ack_o <= accept;
			if (accept) begin
				cnt_q <= CNT_W'(DELAY);
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// A stalled request stays on the bus unchanged until the bank takes it
	a_stall_hold: assert property (
		@(posedge clk_i) disable iff (rst_i)
		stall_o && cyc_i && stb_i |=> stb_i && $stable(we_i) && $stable(addr_i)
	) else $error("wb_sram: request dropped or changed while stalled");

	// The router must only steer in-range word indexes here
	a_addr_range: assert property (
		@(posedge clk_i) disable iff (rst_i)
		accept |-> (addr_i < WORDS)
	) else $error("wb_sram: accepted address %0d beyond %0d words", addr_i, WORDS);

	a_ack_spacing: assert property (
		@(posedge clk_i) disable iff (rst_i || DELAY == 0)
		ack_o |=> !ack_o
	) else $error("wb_sram: back-to-back ack with nonzero delay");

endmodule

//--- test/mem_model.svh
/* Reference model of the memory subsystem
   Word arrays for both banks, address decode and byte-masked writes */
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

logic [wb_bus_pkg::DATA_W-1:0] fast_model [mem_map_pkg::FAST_WORDS];
logic [wb_bus_pkg::DATA_W-1:0] slow_model [mem_map_pkg::SLOW_WORDS];

// Each bank spans its word count times the bytes per word from its base
function automatic mem_map_pkg::bank_e decode_addr(input logic [wb_bus_pkg::ADDR_W-1:0] addr);
	int a;
	int fast_lo;
	int slow_lo;
	a = int'(addr);
	fast_lo = int'(mem_map_pkg::FAST_BASE);
	slow_lo = int'(mem_map_pkg::SLOW_BASE);
	if (a >= fast_lo && a < fast_lo + mem_map_pkg::FAST_WORDS * wb_bus_pkg::SEL_W) begin
		return mem_map_pkg::FAST_BANK;
	end
	if (a >= slow_lo && a < slow_lo + mem_map_pkg::SLOW_WORDS * wb_bus_pkg::SEL_W) begin
		return mem_map_pkg::SLOW_BANK;
	end
	return mem_map_pkg::NO_BANK;
endfunction

function automatic int word_offset(input logic [wb_bus_pkg::ADDR_W-1:0] addr,
		input mem_map_pkg::bank_e bank);
	int base;
	base = (bank == mem_map_pkg::SLOW_BANK) ? int'(mem_map_pkg::SLOW_BASE) :
		int'(mem_map_pkg::FAST_BASE);
	return (int'(addr) - base) / wb_bus_pkg::SEL_W;
endfunction

function automatic void model_clear();
	foreach (fast_model[i]) fast_model[i] = '0;
	foreach (slow_model[i]) slow_model[i] = '0;
endfunction

function automatic logic [wb_bus_pkg::DATA_W-1:0] model_read(
		input logic [wb_bus_pkg::ADDR_W-1:0] addr);
	mem_map_pkg::bank_e bank;
	bank = decode_addr(addr);
	if (bank == mem_map_pkg::FAST_BANK) return fast_model[word_offset(addr, bank)];
	if (bank == mem_map_pkg::SLOW_BANK) return slow_model[word_offset(addr, bank)];
	return '0;
endfunction

// Lanes with a clear select bit keep their old byte
function automatic void model_write(input logic [wb_bus_pkg::ADDR_W-1:0] addr,
		input logic [wb_bus_pkg::DATA_W-1:0] data, input logic [wb_bus_pkg::SEL_W-1:0] sel);
	logic [wb_bus_pkg::DATA_W-1:0] word;
	mem_map_pkg::bank_e bank;
	bank = decode_addr(addr);
	word = model_read(addr);
	for (int l = 0; l < wb_bus_pkg::SEL_W; l++) begin
		if (sel[l]) word[l*8 +: 8] = data[l*8 +: 8];
	end
	if (bank == mem_map_pkg::FAST_BANK) fast_model[word_offset(addr, bank)] = word;
	if (bank == mem_map_pkg::SLOW_BANK) slow_model[word_offset(addr, bank)] = word;
endfunction

`endif

//--- test/tb_wb_mem_subsys.sv
/* Testbench for the Wishbone memory subsystem
   Random requests over both banks, checked against a reference model */
`timescale 1ns/1ps

module tb_wb_mem_subsys;

	typedef logic [wb_bus_pkg::ADDR_W-1:0] addr_t;
	typedef logic [wb_bus_pkg::DATA_W-1:0] data_t;
	typedef logic [wb_bus_pkg::SEL_W-1:0]  sel_t;

	localparam int FULL_PAIRS = 8;
	localparam int RANDOM_REQS = 200;
	localparam int UNMAPPED = 6;
	localparam int STALL_REPS = 4;
	localparam int BURST_LEN = 16;
	localparam int TOTAL_REQS = 4 * FULL_PAIRS + RANDOM_REQS + 3 * UNMAPPED +
		3 * STALL_REPS + BURST_LEN;
	localparam int TIMEOUT_CYCLES = TOTAL_REQS * (mem_map_pkg::SLOW_DELAY + 3) + 100;
	localparam int RESP_LIMIT = mem_map_pkg::SLOW_DELAY + 4;

	logic  clk_i;
	logic  rst_i;
	logic  wb_cyc_i;
	logic  wb_stb_i;
	logic  wb_we_i;
	addr_t wb_addr_i;
	data_t wb_data_i;
	sel_t  wb_sel_i;
	logic  wb_stall_o;
	logic  wb_ack_o;
	logic  wb_err_o;
	data_t wb_data_o;

	int error_count = 0;
	int test_start_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;

	`include "mem_model.svh"

	wb_mem_subsys i_wb_mem_subsys (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_addr_i  (wb_addr_i),
		.wb_data_i  (wb_data_i),
		.wb_sel_i   (wb_sel_i),
		.wb_stall_o (wb_stall_o),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o),
		.wb_data_o  (wb_data_o)
	);

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic finish_test(input string name);
		if (error_count == test_start_errors) begin
			$display("Test %s: ok", name);
			tests_passed++;
		end else begin
			$display("Test %s: %0d errors", name, error_count - test_start_errors);
			tests_failed++;
		end
		test_start_errors = error_count;
	endtask

	task automatic check_idle(input string when);
		if (wb_ack_o !== 1'b0 || wb_err_o !== 1'b0 || wb_stall_o !== 1'b0) begin
			report_mismatch($sformatf("outputs not idle %s: ack %b err %b stall %b",
				when, wb_ack_o, wb_err_o, wb_stall_o));
		end
	endtask

	function automatic addr_t pick_addr(input mem_map_pkg::bank_e bank, input int window);
		int word;
		word = $urandom % window;
		if (bank == mem_map_pkg::SLOW_BANK) begin
			return addr_t'(int'(mem_map_pkg::SLOW_BASE) + word * wb_bus_pkg::SEL_W);
		end
		return addr_t'(int'(mem_map_pkg::FAST_BASE) + word * wb_bus_pkg::SEL_W);
	endfunction

	// Either the gap after the fast bank or the space above the slow bank
	function automatic addr_t unmapped_addr(input bit above_slow);
		int lo;
		int hi;
		lo = above_slow ? int'(mem_map_pkg::SLOW_BASE) + mem_map_pkg::SLOW_WORDS * 4 :
			int'(mem_map_pkg::FAST_BASE) + mem_map_pkg::FAST_WORDS * 4;
		hi = above_slow ? 65536 : int'(mem_map_pkg::SLOW_BASE);
		return addr_t'(lo + ($urandom % ((hi - lo) / 4)) * 4);
	endfunction

	// Called on a falling edge, returns on the falling edge where the response is seen
	task automatic check_access(input logic we, input addr_t addr, input data_t wdata,
			input sel_t sel, output int stalls);
		logic  stalled;
		logic  accepted;
		logic  got_ack;
		logic  got_err;
		logic  exp_err;
		data_t expected;
		exp_err = (decode_addr(addr) == mem_map_pkg::NO_BANK);
		expected = model_read(addr);
		stalls = 0;
		accepted = 1'b0;
		got_ack = 1'b0;
		got_err = 1'b0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_addr_i = addr;
		wb_data_i = wdata;
		wb_sel_i = sel;
		// Stall is read on the rising edge where the request is taken or refused
		while (!accepted && stalls <= RESP_LIMIT) begin
			@(posedge clk_i);
			stalled = (wb_stall_o === 1'b1);
			@(negedge clk_i);
			got_ack = (wb_ack_o === 1'b1);
			got_err = (wb_err_o === 1'b1);
			if (stalled) begin
				stalls++;
				if (got_ack || got_err) begin
					report_mismatch($sformatf("response at address %h while it was stalled",
						addr));
				end
			end else begin
				accepted = 1'b1;
			end
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		if (!accepted) begin
			report_failure($sformatf("request at address %h still stalled after %0d cycles",
				addr, stalls));
			return;
		end
		if (!got_ack && !got_err) begin
			report_failure($sformatf("no ack or err one cycle after the request at address %h",
				addr));
			return;
		end
		if (got_ack && got_err) begin
			report_mismatch($sformatf("ack and err together at address %h", addr));
		end else if (exp_err && !got_err) begin
			report_mismatch($sformatf("ack instead of err at unmapped address %h", addr));
		end else if (!exp_err && !got_ack) begin
			report_mismatch($sformatf("err instead of ack at mapped address %h", addr));
		end else if (!we && wb_data_o !== expected) begin
			report_mismatch($sformatf("read %h at address %h, expected %h",
				wb_data_o, addr, expected));
		end
		if (we && !exp_err) model_write(addr, wdata, sel);
	endtask

	// Back-to-back reads, one new request on every falling edge
	task automatic burst_reads();
		addr_t addrs [BURST_LEN];
		data_t expected [BURST_LEN];
		for (int k = 0; k < BURST_LEN; k++) begin
			addrs[k] = pick_addr(mem_map_pkg::FAST_BANK, mem_map_pkg::FAST_WORDS);
			expected[k] = model_read(addrs[k]);
		end
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = 1'b0;
		wb_sel_i = '1;
		wb_addr_i = addrs[0];
		for (int k = 0; k < BURST_LEN; k++) begin
			@(negedge clk_i);
			if (wb_stall_o !== 1'b0) begin
				report_mismatch($sformatf("stall during fast burst at read %0d", k));
			end
			if (wb_ack_o !== 1'b1) begin
				report_failure($sformatf("burst read %0d got no ack one cycle later", k));
			end else if (wb_data_o !== expected[k]) begin
				report_mismatch($sformatf("burst read %0d at %h returned %h, expected %h",
					k, addrs[k], wb_data_o, expected[k]));
			end
			if (k + 1 < BURST_LEN) begin
				wb_addr_i = addrs[k+1];
			end else begin
				wb_cyc_i = 1'b0;
				wb_stb_i = 1'b0;
			end
		end
		@(negedge clk_i);
		if (wb_ack_o !== 1'b0) report_mismatch("extra ack after the fast burst");
	endtask

	initial begin
		int    stalls;
		addr_t addr;
		mem_map_pkg::bank_e bank;
		clk_i = 1'b0;
		rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_addr_i = '0;
		wb_data_i = '0;
		wb_sel_i = '0;
		void'($urandom(32'h150c));
		model_clear();

		repeat (4) begin
			@(negedge clk_i);
			check_idle("during reset");
		end
		rst_i = 1'b0;
		@(negedge clk_i);
		check_idle("after reset");
		finish_test("reset state");

		for (int b = 0; b < 2; b++) begin
			bank = (b == 0) ? mem_map_pkg::FAST_BANK : mem_map_pkg::SLOW_BANK;
			for (int i = 0; i < FULL_PAIRS; i++) begin
				addr = pick_addr(bank, (b == 0) ? mem_map_pkg::FAST_WORDS :
					mem_map_pkg::SLOW_WORDS);
				check_access(1'b1, addr, data_t'($urandom), '1, stalls);
				check_access(1'b0, addr, '0, '1, stalls);
			end
		end
		finish_test("full-word write and read");

		// A small window per bank so that reads often hit earlier writes
		for (int i = 0; i < RANDOM_REQS; i++) begin
			bank = ($urandom % 2) ? mem_map_pkg::SLOW_BANK : mem_map_pkg::FAST_BANK;
			addr = pick_addr(bank, 16);
			check_access(1'($urandom % 2), addr, data_t'($urandom), sel_t'($urandom), stalls);
		end
		finish_test("random byte-select traffic");

		for (int i = 0; i < UNMAPPED; i++) begin
			addr = unmapped_addr(i % 2);
			check_access(1'b1, addr, data_t'($urandom), '1, stalls);
			@(negedge clk_i);
			if (wb_err_o !== 1'b0 || wb_ack_o !== 1'b0) begin
				report_mismatch($sformatf("err or ack lingers after unmapped address %h", addr));
			end
			// Read the words a truncated decode would have hit
			check_access(1'b0, addr_t'(((addr / 4) % mem_map_pkg::FAST_WORDS) * 4), '0, '1,
				stalls);
			check_access(1'b0, addr_t'(int'(mem_map_pkg::SLOW_BASE) +
				((addr / 4) % mem_map_pkg::SLOW_WORDS) * 4), '0, '1, stalls);
		end
		finish_test("unmapped addresses");

		for (int i = 0; i < STALL_REPS; i++) begin
			check_access(1'b1, pick_addr(mem_map_pkg::SLOW_BANK, 64), data_t'($urandom), '1,
				stalls);
			check_access(1'b0, pick_addr(mem_map_pkg::SLOW_BANK, 64), '0, '1, stalls);
			if (stalls != mem_map_pkg::SLOW_DELAY) begin
				report_mismatch($sformatf("slow request stalled %0d cycles, expected %0d",
					stalls, mem_map_pkg::SLOW_DELAY));
			end
			check_access(1'b0, pick_addr(mem_map_pkg::FAST_BANK, 64), '0, '1, stalls);
			if (stalls != 0) begin
				report_mismatch($sformatf("fast request after slow stalled %0d cycles", stalls));
			end
		end
		finish_test("slow-bank stall");

		burst_reads();
		finish_test("fast-bank throughput");

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
